/* common/ex_config.svh */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path width
`define EX_XLEN      32

`define EX_RF_AW     5          // Register file address width

// One multiplier bit per iteration
`define EX_MUL_STEPS `EX_XLEN

`endif

/* common/ex_pkg.sv */
`include "ex_config.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]  xword_t;     // Data word
    typedef logic [`EX_RF_AW-1:0] rf_add_t;    // Destination register address

    // Execution unit selected by decode
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_LSU = 2'd2
    } ex_unit_e;

    // LSU codes keep bit 3 set, stores also have bit 2 set
    typedef enum logic [3:0] {
        FN_ADD = 4'h0,
        FN_SUB = 4'h1,
        FN_AND = 4'h2,
        FN_OR  = 4'h3,
        FN_XOR = 4'h4,
        FN_SLT = 4'h5,
        FN_MUL = 4'h6,          // Low word of the product
        FN_LB  = 4'h8,
        FN_LH  = 4'h9,
        FN_LW  = 4'hA,
        FN_SB  = 4'hC,
        FN_SH  = 4'hD,
        FN_SW  = 4'hE
    } ex_func_e;

    typedef enum logic [1:0] {
        IMISCON_FREE = 2'd0,
        IMISCON_MISA = 2'd1,    // Misaligned LSU access
        IMISCON_DSCR = 2'd2     // Replica discrepancy
    } imiscon_e;

    // Bit 0/1 take op1/op2 from EXMA, bit 2/3 from MA/WB
    typedef logic [3:0] fwd_sel_t;

    typedef struct packed {
        xword_t   op1;
        xword_t   op2;
        xword_t   imm;
        ex_unit_e unit;
        ex_func_e func;
        rf_add_t  rd;
        fwd_sel_t fwd;
    } opex_t;

    typedef struct packed {
        xword_t   val;          // Result or LSU address
        xword_t   wdata;        // Store data
        rf_add_t  rd;
        ex_func_e func;
        ex_unit_e unit;
        imiscon_e imiscon;
    } exma_t;

endpackage

/* executor/seq_multiplier.sv */
`timescale 1ns/1ps

`include "ex_config.svh"

module seq_multiplier (
    input  logic           s_clk_i,
    input  logic           rst_n_i,
    input  logic           abort_i,
    input  logic           start_i,
    input  ex_pkg::xword_t multiplicand_i,
    input  ex_pkg::xword_t multiplier_i,
    output logic           busy_o,
    output logic           done_o,
    output ex_pkg::xword_t product_o
);
    localparam int CNT_W = $clog2(`EX_MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EX_MUL_STEPS - 1);

    typedef enum logic [1:0] {IDLE, RUN, DONE} mul_state_e;

    mul_state_e       state_q;
    logic [CNT_W-1:0] step_q;
    ex_pkg::xword_t   mcand_q;      // Shifted left every step
    ex_pkg::xword_t   mplier_q;     // Shifted right, bit 0 is the current bit
    ex_pkg::xword_t   acc_q;

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i || abort_i) begin
            state_q <= IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == LAST_STEP) begin
                        state_q <= DONE;
                    end
                end
                // DONE lasts a single cycle
                default: begin
                    step_q  <= '0;
                    state_q <= start_i ? RUN : IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (start_i && state_q != RUN) begin
            mcand_q  <= multiplicand_i;
            mplier_q <= multiplier_i;
            acc_q    <= '0;
        end else if (state_q == RUN) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;       // Only the low word is kept
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign busy_o    = (state_q == RUN);
    assign done_o    = (state_q == DONE);
    assign product_o = acc_q;

endmodule

/* executor/executor.sv */
`timescale 1ns/1ps

module executor (
    input  logic           s_clk_i,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic           start_i,
    input  ex_pkg::opex_t  opex_i,
    input  ex_pkg::xword_t mawb_val_i,
    input  ex_pkg::xword_t exma_val_i,
    output ex_pkg::xword_t result_o,
    output ex_pkg::xword_t wdata_o,
    output logic           finished_o
);
    ex_pkg::xword_t operand1;
    ex_pkg::xword_t operand2;
    ex_pkg::xword_t alu_res;
    ex_pkg::xword_t lsu_addr;
    ex_pkg::xword_t product;
    logic           mul_busy;
    logic           mul_done;

    // EXMA value is younger than MA/WB, so it has priority
    assign operand1 = opex_i.fwd[0] ? exma_val_i :
                      opex_i.fwd[2] ? mawb_val_i : opex_i.op1;
    assign operand2 = opex_i.fwd[1] ? exma_val_i :
                      opex_i.fwd[3] ? mawb_val_i : opex_i.op2;

    assign wdata_o  = operand2;                 // Store data
    assign lsu_addr = operand1 + opex_i.imm;

    always_comb begin
        case (opex_i.func)
            ex_pkg::FN_ADD: alu_res = operand1 + operand2;
            ex_pkg::FN_SUB: alu_res = operand1 - operand2;
            ex_pkg::FN_AND: alu_res = operand1 & operand2;
            ex_pkg::FN_OR:  alu_res = operand1 | operand2;
            ex_pkg::FN_XOR: alu_res = operand1 ^ operand2;
            // Signed compare, result zero extended
            ex_pkg::FN_SLT: alu_res = ex_pkg::xword_t'($signed(operand1) < $signed(operand2));
            default:        alu_res = operand1 + operand2;
        endcase
    end

    // Operands are latched inside on start, later forwarding changes are harmless
    seq_multiplier m_mul (
        .s_clk_i        (s_clk_i),
        .rst_n_i        (rst_n_i),
        .abort_i        (flush_i),
        .start_i        (start_i),
        .multiplicand_i (operand1),
        .multiplier_i   (operand2),
        .busy_o         (mul_busy),
        .done_o         (mul_done),
        .product_o      (product)
    );

    // The OPEX word may already belong to the next instruction when the product is ready
    always_comb begin
        if (mul_done) begin
            result_o = product;
        end else begin
            case (opex_i.unit)
                ex_pkg::UNIT_LSU: result_o = lsu_addr;
                ex_pkg::UNIT_MUL: result_o = product;
                default:          result_o = alu_res;
            endcase
        end
    end

    // ALU and LSU finish at once, a MUL on the done cycle
    assign finished_o = ~mul_busy & (mul_done | (opex_i.unit != ex_pkg::UNIT_MUL));

endmodule

/* src/exma_merge.sv */
`timescale 1ns/1ps

module exma_merge (
    input  logic           s_clk_i,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic           opex_valid_i,
    input  ex_pkg::opex_t  opex_i,
    input  ex_pkg::xword_t res0_i,
    input  ex_pkg::xword_t res1_i,
    input  ex_pkg::xword_t wdata0_i,
    input  ex_pkg::xword_t wdata1_i,
    input  logic           fin0_i,
    input  logic           fin1_i,
    input  logic           exma_ready_i,
    output logic           opex_ready_o,
    output logic           start_o,
    output logic           exma_valid_o,
    output ex_pkg::exma_t  exma_o,
    output logic           exma_neq_o
);
    logic          exma_valid_q;
    logic          mul_pend_q;      // MUL started, product not yet loaded
    ex_pkg::exma_t exma_q;
    ex_pkg::exma_t mul_base_q;      // Fields of the pending MUL
    ex_pkg::exma_t op_rec;
    ex_pkg::exma_t mul_rec;
    logic          out_free;
    logic          is_mul;
    logic          is_half;
    logic          is_word;
    logic          xfer;
    logic          load_op;
    logic          load_mul;
    logic          res_neq;
    logic          wd_neq;
    logic          misa;

    // Register empty or being drained this cycle
    assign out_free     = ~exma_valid_q | exma_ready_i;
    assign opex_ready_o = ~flush_i & ~mul_pend_q & out_free;
    assign xfer         = opex_valid_i & opex_ready_o;

    assign is_mul   = (opex_i.unit == ex_pkg::UNIT_MUL);
    assign start_o  = xfer & is_mul;
    assign load_op  = xfer & ~is_mul;
    // Nothing is accepted while the multiplier runs, so the register is free here
    assign load_mul = mul_pend_q & (fin0_i | fin1_i);

    // A finish seen by one replica only is a discrepancy too
    assign res_neq = (res0_i != res1_i) | (fin0_i != fin1_i);
    assign wd_neq  = (wdata0_i != wdata1_i);

    assign is_half = (opex_i.func == ex_pkg::FN_LH) || (opex_i.func == ex_pkg::FN_SH);
    assign is_word = (opex_i.func == ex_pkg::FN_LW) || (opex_i.func == ex_pkg::FN_SW);
    assign misa    = (opex_i.unit == ex_pkg::UNIT_LSU) &
                     ((is_half & res0_i[0]) | (is_word & (|res0_i[1:0])));

    always_comb begin
        op_rec.val   = res0_i;
        op_rec.wdata = wdata0_i;
        op_rec.rd    = opex_i.rd;
        op_rec.func  = opex_i.func;
        op_rec.unit  = opex_i.unit;
        if (res_neq || wd_neq) begin
            op_rec.imiscon = ex_pkg::IMISCON_DSCR;      // Wins over MISA
        end else if (misa) begin
            op_rec.imiscon = ex_pkg::IMISCON_MISA;
        end else begin
            op_rec.imiscon = ex_pkg::IMISCON_FREE;
        end
    end

    // Product joins the fields saved at start
    always_comb begin
        mul_rec     = mul_base_q;
        mul_rec.val = res0_i;
        if (res_neq) begin
            mul_rec.imiscon = ex_pkg::IMISCON_DSCR;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i || flush_i) begin
            exma_valid_q <= 1'b0;
            mul_pend_q   <= 1'b0;
        end else begin
            if (load_op || load_mul) begin
                exma_valid_q <= 1'b1;
            end else if (exma_ready_i) begin
                exma_valid_q <= 1'b0;
            end
            if (start_o) begin
                mul_pend_q <= 1'b1;
            end else if (load_mul) begin
                mul_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (load_mul) begin
            exma_q <= mul_rec;
        end else if (load_op) begin
            exma_q <= op_rec;
        end
        if (start_o) begin
            mul_base_q         <= op_rec;
            // Write data is compared now, the product on completion
            mul_base_q.imiscon <= wd_neq ? ex_pkg::IMISCON_DSCR : ex_pkg::IMISCON_FREE;
        end
    end

    assign exma_valid_o = exma_valid_q;
    assign exma_o       = exma_q;
    assign exma_neq_o   = exma_valid_q & (exma_q.imiscon == ex_pkg::IMISCON_DSCR);

endmodule

/* src/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic           s_clk_i,
    input  logic           rst_n_i,
    input  logic           flush_i,
    input  logic           opex_valid_i,
    input  ex_pkg::opex_t  opex_i,
    input  ex_pkg::xword_t mawb_val_i,
    input  logic           exma_ready_i,
    output logic           opex_ready_o,
    output logic           exma_valid_o,
    output ex_pkg::exma_t  exma_o,
    output logic           exma_neq_o
);
    ex_pkg::xword_t res_0;
    ex_pkg::xword_t res_1;
    ex_pkg::xword_t wdata_0;
    ex_pkg::xword_t wdata_1;
    logic           fin_0;
    logic           fin_1;
    logic           mul_start;

    // Both replicas see the same OPEX word and forwarding sources
    executor m_executor_0 (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .start_i    (mul_start),
        .opex_i     (opex_i),
        .mawb_val_i (mawb_val_i),
        .exma_val_i (exma_o.val),
        .result_o   (res_0),
        .wdata_o    (wdata_0),
        .finished_o (fin_0)
    );

    executor m_executor_1 (
        .s_clk_i    (s_clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .start_i    (mul_start),
        .opex_i     (opex_i),
        .mawb_val_i (mawb_val_i),
        .exma_val_i (exma_o.val),
        .result_o   (res_1),
        .wdata_o    (wdata_1),
        .finished_o (fin_1)
    );

    exma_merge m_merge (
        .s_clk_i      (s_clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .opex_valid_i (opex_valid_i),
        .opex_i       (opex_i),
        .res0_i       (res_0),
        .res1_i       (res_1),
        .wdata0_i     (wdata_0),
        .wdata1_i     (wdata_1),
        .fin0_i       (fin_0),
        .fin1_i       (fin_1),
        .exma_ready_i (exma_ready_i),
        .opex_ready_o (opex_ready_o),
        .start_o      (mul_start),
        .exma_valid_o (exma_valid_o),
        .exma_o       (exma_o),
        .exma_neq_o   (exma_neq_o)
    );

endmodule

/* sim/ex_stage_sva.sv */
`timescale 1ns/1ps

module ex_stage_sva (
    input logic          s_clk_i,
    input logic          rst_n_i,
    input logic          flush_i,
    input logic          exma_valid_o,
    input logic          exma_ready_i,
    input ex_pkg::exma_t exma_o,
    input logic          exma_neq_o
);
    // Output record frozen until the consumer accepts
    a_exma_hold: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        exma_valid_o && !exma_ready_i && !flush_i |=> exma_valid_o && $stable(exma_o))
        else $error("EXMA record changed under back-pressure");

    // No fault injected, so replicas always agree
    a_no_dscr: assert property (@(posedge s_clk_i) disable iff (!rst_n_i) !exma_neq_o)
        else $error("Replica discrepancy flagged");

    a_flush_clr: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
        flush_i |=> !exma_valid_o)
        else $error("EXMA valid in the cycle after a flush");

endmodule

bind ex_stage ex_stage_sva m_sva (
    .s_clk_i      (s_clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .exma_valid_o (exma_valid_o),
    .exma_ready_i (exma_ready_i),
    .exma_o       (exma_o),
    .exma_neq_o   (exma_neq_o)
);

/* sim/tb_ex_stage.sv */
`timescale 1ns/1ps

`include "ex_config.svh"

module tb_ex_stage;
    localparam int MUL_LAT   = `EX_MUL_STEPS + 4;     // Upper bound for one product
    localparam int NUM_OPS   = 64;                    // All operations of all tests, rounded up
    localparam int CYC_LIMIT = NUM_OPS * MUL_LAT + 400;

    logic           s_clk;
    logic           rst_n;
    logic           flush;
    logic           opex_valid;
    ex_pkg::opex_t  opex;
    ex_pkg::xword_t mawb_val;
    logic           exma_ready;
    logic           opex_ready;
    logic           exma_valid;
    ex_pkg::exma_t  exma;
    logic           exma_neq;

    int          cycle_cnt    = 0;
    int          err_cnt      = 0;
    int          test_err     = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    ex_stage dut (
        .s_clk_i      (s_clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .opex_valid_i (opex_valid),
        .opex_i       (opex),
        .mawb_val_i   (mawb_val),
        .exma_ready_i (exma_ready),
        .opex_ready_o (opex_ready),
        .exma_valid_o (exma_valid),
        .exma_o       (exma),
        .exma_neq_o   (exma_neq)
    );

    always #2 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYC_LIMIT) begin
            $display("Timeout after %0d cycles", cycle_cnt);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic ex_pkg::opex_t build_op(ex_pkg::ex_unit_e unit, ex_pkg::ex_func_e func,
                                               ex_pkg::xword_t op1, ex_pkg::xword_t op2,
                                               ex_pkg::xword_t imm, ex_pkg::fwd_sel_t fwd);
        ex_pkg::opex_t op;
        op.op1  = op1;
        op.op2  = op2;
        op.imm  = imm;
        op.unit = unit;
        op.func = func;
        op.rd   = ex_pkg::rf_add_t'($urandom_range(31, 1));
        op.fwd  = fwd;
        return op;
    endfunction

    function automatic ex_pkg::exma_t expect_rec(ex_pkg::opex_t op, ex_pkg::xword_t val,
                                                 ex_pkg::xword_t wdata, ex_pkg::imiscon_e code);
        ex_pkg::exma_t rec;
        rec.val     = val;
        rec.wdata   = wdata;
        rec.rd      = op.rd;
        rec.func    = op.func;
        rec.unit    = op.unit;
        rec.imiscon = code;
        return rec;
    endfunction

    function automatic ex_pkg::xword_t alu_model(ex_pkg::ex_func_e func, ex_pkg::xword_t a,
                                                 ex_pkg::xword_t b);
        case (func)
            ex_pkg::FN_SUB: return a - b;
            ex_pkg::FN_AND: return a & b;
            ex_pkg::FN_OR:  return a | b;
            ex_pkg::FN_XOR: return a ^ b;
            ex_pkg::FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:        return a + b;
        endcase
    endfunction

    // Halfword at an odd address, word off a 4 byte boundary
    function automatic bit misaligned(ex_pkg::ex_func_e func, ex_pkg::xword_t addr);
        if (func == ex_pkg::FN_LH || func == ex_pkg::FN_SH) return addr[0];
        if (func == ex_pkg::FN_LW || func == ex_pkg::FN_SW) return addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    task automatic issue(input ex_pkg::opex_t op, input ex_pkg::xword_t mv);
        @(posedge s_clk);
        opex       <= op;
        mawb_val   <= mv;
        opex_valid <= 1'b1;
        do begin
            @(negedge s_clk);
        end while (!opex_ready);
        @(posedge s_clk);                       // Transfer edge
        opex_valid <= 1'b0;
    endtask

    // Without an injected fault the discrepancy flag stays low
    task automatic replicas_agree(input string name);
        assert (!exma_neq) else begin
            $display("Fail %s: expected exma_neq 0, actual %b", name, exma_neq);
            test_err++;
        end
    endtask

    task automatic collect(input string name, input int limit, output ex_pkg::exma_t rec,
                           output int cycles);
        cycles = 0;
        rec    = '0;
        do begin
            @(negedge s_clk);
            cycles++;
            if (!exma_valid) begin
                assert (!opex_ready) else begin
                    $display("Error %s: stage ready while an operation is pending", name);
                    test_err++;
                end
            end
        end while (!exma_valid && cycles < limit);
        assert (exma_valid) else begin
            $display("Error %s: no result within %0d cycles", name, limit);
            test_err++;
        end
        replicas_agree(name);
        rec = exma;
    endtask

    task automatic check_rec(input string name, input ex_pkg::exma_t exp,
                             input ex_pkg::exma_t act);
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            test_err++;
        end
    endtask

    task automatic check_out(input string name, input ex_pkg::exma_t exp);
        assert (exma_valid) else begin
            $display("Error %s: output valid dropped before it was accepted", name);
            test_err++;
        end
        replicas_agree(name);
        check_rec(name, exp, exma);
    endtask

    // ALU and LSU results are due one cycle after acceptance
    task automatic run_single(input string name, input ex_pkg::opex_t op,
                              input ex_pkg::xword_t mv, input ex_pkg::exma_t exp);
        ex_pkg::exma_t rec;
        int            cycles;
        issue(op, mv);
        collect(name, MUL_LAT, rec, cycles);
        assert (cycles == 1) else begin
            $display("Error %s: result came %0d cycles after acceptance", name, cycles);
            test_err++;
        end
        check_rec(name, exp, rec);
    endtask

    task automatic end_test(input string name);
        if (test_err == 0) begin
            $display("Test %s: passed", name);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d errors", name, test_err);
            tests_failed++;
        end
        err_cnt += test_err;
        test_err = 0;
    endtask

    task automatic alu_ops();
        ex_pkg::ex_func_e fns[6] = '{ex_pkg::FN_ADD, ex_pkg::FN_SUB, ex_pkg::FN_AND,
                                     ex_pkg::FN_OR, ex_pkg::FN_XOR, ex_pkg::FN_SLT};
        ex_pkg::opex_t    op;
        for (int i = 0; i < 12; i++) begin
            op = build_op(ex_pkg::UNIT_ALU, fns[i % 6], $urandom(), $urandom(), '0, '0);
            run_single("alu", op, $urandom(), expect_rec(op, alu_model(op.func, op.op1, op.op2),
                                                         op.op2, ex_pkg::IMISCON_FREE));
        end
        end_test("alu");
    endtask

    task automatic forwarding();
        ex_pkg::fwd_sel_t sels[7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                      4'b0101, 4'b1010, 4'b1111};
        ex_pkg::opex_t    op;
        ex_pkg::xword_t   last;
        ex_pkg::xword_t   mv;
        ex_pkg::xword_t   a;
        ex_pkg::xword_t   b;
        op   = build_op(ex_pkg::UNIT_ALU, ex_pkg::FN_ADD, $urandom(), $urandom(), '0, '0);
        last = op.op1 + op.op2;                 // Known EXMA value to forward from
        run_single("fwd", op, $urandom(), expect_rec(op, last, op.op2, ex_pkg::IMISCON_FREE));
        for (int i = 0; i < 7; i++) begin
            mv = $urandom();
            op = build_op(ex_pkg::UNIT_ALU, (i % 2) ? ex_pkg::FN_SUB : ex_pkg::FN_XOR,
                          $urandom(), $urandom(), '0, sels[i]);
            a  = sels[i][0] ? last : (sels[i][2] ? mv : op.op1);
            b  = sels[i][1] ? last : (sels[i][3] ? mv : op.op2);
            run_single("fwd", op, mv, expect_rec(op, alu_model(op.func, a, b), b,
                                                 ex_pkg::IMISCON_FREE));
            last = alu_model(op.func, a, b);
        end
        end_test("fwd");
    endtask

    task automatic mul_ops();
        ex_pkg::opex_t  op;
        ex_pkg::exma_t  rec;
        ex_pkg::xword_t prod;
        int             cycles;
        for (int i = 0; i < 6; i++) begin
            op   = build_op(ex_pkg::UNIT_MUL, ex_pkg::FN_MUL, $urandom(), $urandom(), '0, '0);
            prod = op.op1 * op.op2;             // Low word only
            issue(op, $urandom());
            collect("mul", MUL_LAT, rec, cycles);
            check_rec("mul", expect_rec(op, prod, op.op2, ex_pkg::IMISCON_FREE), rec);
        end
        end_test("mul");
    endtask

    task automatic lsu_access();
        ex_pkg::ex_func_e fns[6] = '{ex_pkg::FN_LB, ex_pkg::FN_LH, ex_pkg::FN_LW,
                                     ex_pkg::FN_SB, ex_pkg::FN_SH, ex_pkg::FN_SW};
        ex_pkg::opex_t    op;
        ex_pkg::xword_t   addr;
        ex_pkg::imiscon_e code;
        for (int i = 0; i < 6; i++) begin
            for (int ofs = 0; ofs < 4; ofs++) begin
                // Low address bits come from ofs alone
                op   = build_op(ex_pkg::UNIT_LSU, fns[i], $urandom() & ~32'h3, $urandom(),
                                ($urandom() & ~32'h3) | 32'(ofs), '0);
                addr = op.op1 + op.imm;
                code = misaligned(op.func, addr) ? ex_pkg::IMISCON_MISA : ex_pkg::IMISCON_FREE;
                run_single("lsu", op, $urandom(), expect_rec(op, addr, op.op2, code));
            end
        end
        end_test("lsu");
    endtask

    task automatic backpressure();
        ex_pkg::opex_t op_a;
        ex_pkg::opex_t op_b;
        op_a = build_op(ex_pkg::UNIT_ALU, ex_pkg::FN_OR, $urandom(), $urandom(), '0, '0);
        op_b = build_op(ex_pkg::UNIT_ALU, ex_pkg::FN_AND, $urandom(), $urandom(), '0, '0);
        @(posedge s_clk);
        exma_ready <= 1'b0;
        issue(op_a, $urandom());
        @(posedge s_clk);
        opex       <= op_b;                     // Offered while the register is full
        opex_valid <= 1'b1;
        repeat (5) begin
            @(negedge s_clk);
            assert (!opex_ready) else begin
                $display("Error bp: input accepted under back-pressure");
                test_err++;
            end
            check_out("bp", expect_rec(op_a, op_a.op1 | op_a.op2, op_a.op2,
                                       ex_pkg::IMISCON_FREE));
        end
        @(posedge s_clk);
        exma_ready <= 1'b1;
        @(negedge s_clk);
        check_out("bp", expect_rec(op_a, op_a.op1 | op_a.op2, op_a.op2, ex_pkg::IMISCON_FREE));
        @(posedge s_clk);                       // A drained, B taken
        opex_valid <= 1'b0;
        @(negedge s_clk);
        check_out("bp", expect_rec(op_b, op_b.op1 & op_b.op2, op_b.op2, ex_pkg::IMISCON_FREE));
        end_test("bp");
    endtask

    task automatic flush_mul();
        ex_pkg::opex_t op;
        op = build_op(ex_pkg::UNIT_MUL, ex_pkg::FN_MUL, $urandom(), $urandom(), '0, '0);
        issue(op, $urandom());
        repeat (6) @(posedge s_clk);
        flush <= 1'b1;
        @(posedge s_clk);
        flush <= 1'b0;
        repeat (MUL_LAT) begin
            @(negedge s_clk);
            assert (!exma_valid) else begin
                $display("Error flush: flushed multiply still produced a result");
                test_err++;
            end
        end
        op = build_op(ex_pkg::UNIT_ALU, ex_pkg::FN_SUB, $urandom(), $urandom(), '0, '0);
        run_single("flush", op, $urandom(), expect_rec(op, op.op1 - op.op2, op.op2,
                                                       ex_pkg::IMISCON_FREE));
        end_test("flush");
    endtask

    initial begin
        void'($urandom(80));
        s_clk      = 1'b0;
        rst_n      = 1'b0;
        flush      = 1'b0;
        opex_valid = 1'b0;
        opex       = '0;
        mawb_val   = '0;
        exma_ready = 1'b1;
        repeat (8) @(posedge s_clk);
        rst_n <= 1'b1;
        alu_ops();
        forwarding();
        mul_ops();
        lsu_access();
        backpressure();
        flush_mul();
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/ex_pkg.sv
executor/seq_multiplier.sv
executor/executor.sv
src/exma_merge.sv
src/ex_stage.sv
sim/ex_stage_sva.sv
sim/tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_ex_stage -Mdir "$OBJ" -o tb_ex_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_ex_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
